//--- compile.f
source/microwave_pkg.sv
source/command_decode.sv
source/cook_timer.sv
source/power_pwm.sv
source/display_alarm.sv
source/microwave_top.sv
verification/microwave_checker.sv
verification/microwave_tb.sv

//--- Bender.yml
package:
  name: microwave

sources:
  - source/microwave_pkg.sv
  - source/command_decode.sv
  - source/cook_timer.sv
  - source/power_pwm.sv
  - source/display_alarm.sv
  - source/microwave_top.sv
  - target: test
    files:
      - verification/microwave_checker.sv
      - verification/microwave_tb.sv

//--- verification/microwave_tb.sv
`timescale 1ns/10ps
`default_nettype none

module microwave_tb;
    import microwave_pkg::*;

    localparam int TICK_CYCLES = 16;
    localparam int BEEP_TICKS  = 3;

    // worst case length of each test in clock cycles
    localparam int SETUP_CYCLES     = 60;
    localparam int KEYPAD_CYCLES    = 6 * 40;
    localparam int PRESET_CYCLES    = 8 * 30;
    localparam int ADD_CYCLES       = 215 * 6;
    localparam int COUNTDOWN_CYCLES = 4 * (6 * TICK_CYCLES + (BEEP_TICKS + 1) * TICK_CYCLES + 30);
    localparam int STOP_CYCLES      = 8 * 90;
    localparam int PWM_CYCLES       = 6 * 340;
    localparam int MAX_CYCLES = 2 * (SETUP_CYCLES + KEYPAD_CYCLES + PRESET_CYCLES + ADD_CYCLES
                                     + COUNTDOWN_CYCLES + STOP_CYCLES + PWM_CYCLES);

    logic         clk = 1'b0;
    logic         reset;
    logic [3:0]   key_digit;
    logic         key_strobe;
    food_e        food;
    logic         preset_strobe;
    logic         start;
    logic         stop;
    cook_state_t  state;
    time_digits_t digits;
    logic [6:0]   seg_1;
    logic [6:0]   seg_2;
    logic [6:0]   seg_3;
    logic [6:0]   seg_4;
    logic         magnetron;
    logic         buzzer;
    logic [7:0]   power;
    logic [7:0]   temperature;
    logic [3:0]   test_id;
    logic         test_end;
    logic         run_end;
    int           error_count;
    int           cycle_count = 0;
    logic [31:0]  rng_state;

    always #5 clk = ~clk;

    microwave_top #(
        .TICK_CYCLES (TICK_CYCLES),
        .BEEP_TICKS  (BEEP_TICKS)
    ) DUT (
        .clk           (clk),
        .reset         (reset),
        .key_digit     (key_digit),
        .key_strobe    (key_strobe),
        .food          (food),
        .preset_strobe (preset_strobe),
        .start         (start),
        .stop          (stop),
        .state         (state),
        .digits        (digits),
        .seg_1         (seg_1),
        .seg_2         (seg_2),
        .seg_3         (seg_3),
        .seg_4         (seg_4),
        .magnetron     (magnetron),
        .buzzer        (buzzer),
        .power         (power),
        .temperature   (temperature)
    );

    microwave_checker #(
        .TICK_CYCLES (TICK_CYCLES),
        .BEEP_TICKS  (BEEP_TICKS)
    ) u_checker (
        .clk           (clk),
        .reset         (reset),
        .key_digit     (key_digit),
        .key_strobe    (key_strobe),
        .food          (food),
        .preset_strobe (preset_strobe),
        .start         (start),
        .stop          (stop),
        .state         (state),
        .digits        (digits),
        .seg_1         (seg_1),
        .seg_2         (seg_2),
        .seg_3         (seg_3),
        .seg_4         (seg_4),
        .magnetron     (magnetron),
        .buzzer        (buzzer),
        .power         (power),
        .temperature   (temperature),
        .test_id       (test_id),
        .test_end      (test_end),
        .run_end       (run_end),
        .error_count   (error_count)
    );

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic int random_below(input int n);
        rng_state = xorshift(rng_state);
        return int'(rng_state % 32'(n));
    endfunction

    // strobes and levels fall back to low on every falling edge
    task automatic next_cycle();
        @(negedge clk);
        key_strobe    = 1'b0;
        preset_strobe = 1'b0;
        start         = 1'b0;
        stop          = 1'b0;
        test_end      = 1'b0;
        run_end       = 1'b0;
    endtask

    task automatic wait_cycles(input int n);
        repeat (n) next_cycle();
    endtask

    task automatic press_key(input logic [3:0] digit);
        next_cycle();
        key_digit  = digit;
        key_strobe = 1'b1;
        next_cycle();
    endtask

    task automatic choose_preset(input food_e item);
        next_cycle();
        food          = item;
        preset_strobe = 1'b1;
        next_cycle();
    endtask

    task automatic press_start();
        next_cycle();
        start = 1'b1;
        next_cycle();
        next_cycle();  // low again so the next press is a new edge
    endtask

    task automatic press_stop();
        next_cycle();
        stop = 1'b1;
        next_cycle();
    endtask

    task automatic wait_cook_end();
        while (state.cooking) begin
            next_cycle();
        end
    endtask

    task automatic wait_buzzer_end();
        while (buzzer) begin
            next_cycle();
        end
    endtask

    task automatic end_test();
        wait_cycles(4);
        test_end = 1'b1;
        next_cycle();
        test_id = test_id + 1'b1;
    endtask

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= MAX_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
            $display("SIMULATION FAILED");
            $finish;
        end
    end

    initial begin
        rng_state     = 32'he7d3;
        reset         = 1'b1;
        key_digit     = 4'd0;
        key_strobe    = 1'b0;
        food          = popcorn;
        preset_strobe = 1'b0;
        start         = 1'b0;
        stop          = 1'b0;
        test_id       = 4'd1;
        test_end      = 1'b0;
        run_end       = 1'b0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        wait_cycles(3);

        // keypad entry, digits above 9 included
        repeat (6) begin
            repeat (1 + random_below(6)) press_key(4'(random_below(12)));
            press_start();
            wait_cycles(4);
            press_stop();
        end
        press_key(4'd9);
        press_key(4'd9);
        press_key(4'd15);  // not a decimal key
        press_key(4'd9);
        press_key(4'd9);  // 99:99 lies above the 99:59 limit
        press_start();
        wait_cycles(4);
        press_stop();
        end_test();

        repeat (8) begin
            choose_preset(food_e'(random_below(10)));
            press_start();
            wait_cycles(4);
            press_stop();
        end
        end_test();

        // quick start, then enough add-30 presses to hit the cap
        press_start();
        repeat (210) press_start();
        press_stop();
        end_test();

        repeat (4) begin
            press_key(4'(1 + random_below(4)));
            press_start();
            wait_cycles(3);
            wait_cook_end();
            wait_buzzer_end();
            wait_cycles(random_below(TICK_CYCLES));
            press_stop();  // clears the digit buffer
        end
        end_test();

        repeat (6) begin
            if (random_below(2) == 0) begin
                choose_preset(food_e'(random_below(10)));
            end else begin
                repeat (1 + random_below(4)) press_key(4'(random_below(10)));
            end
            if (random_below(2) == 0) begin
                press_stop();  // during entry
            end
            press_start();
            wait_cycles(3 + random_below(40));
            press_stop();
            press_start();  // nothing pending, so a quick start
            wait_cycles(4);
            press_stop();
        end
        end_test();

        repeat (6) begin
            choose_preset(food_e'(random_below(10)));
            press_start();
            wait_cycles(300);
            press_stop();
        end
        end_test();

        wait_cycles(2);
        run_end = 1'b1;
        next_cycle();
        next_cycle();
        if (error_count == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- verification/microwave_checker.sv
`timescale 1ns/10ps
`default_nettype none

module microwave_checker #(
    parameter int TICK_CYCLES = 16,
    parameter int BEEP_TICKS  = 3
) (
    input  wire logic                        clk,
    input  wire logic                        reset,
    input  wire logic [3:0]                  key_digit,
    input  wire logic                        key_strobe,
    input  wire microwave_pkg::food_e        food,
    input  wire logic                        preset_strobe,
    input  wire logic                        start,
    input  wire logic                        stop,
    input  wire microwave_pkg::cook_state_t  state,
    input  wire microwave_pkg::time_digits_t digits,
    input  wire logic [6:0]                  seg_1,
    input  wire logic [6:0]                  seg_2,
    input  wire logic [6:0]                  seg_3,
    input  wire logic [6:0]                  seg_4,
    input  wire logic                        magnetron,
    input  wire logic                        buzzer,
    input  wire logic [7:0]                  power,
    input  wire logic [7:0]                  temperature,
    input  wire logic [3:0]                  test_id,
    input  wire logic                        test_end,
    input  wire logic                        run_end,
    output int                               error_count
);
    import microwave_pkg::*;

    cook_state_t   m_state;
    cook_cmd_t     m_cmd;
    cook_setting_t m_pend;
    time_digits_t  m_keys;    // oldest key sits in min_tens
    time_digits_t  m_digits;
    logic          m_start_now;
    logic          m_start_last;
    logic          m_tick;
    logic          m_fin;
    logic          m_mag;
    int            m_beeps;
    int            pwm_phase;
    int            since_reset;
    int            test_errors;
    int            test_checks;
    int            tests_passed;
    int            tests_failed;
    logic          run_done;

    initial begin
        error_count  = 0;
        test_errors  = 0;
        test_checks  = 0;
        tests_passed = 0;
        tests_failed = 0;
        run_done     = 1'b0;
    end

    function automatic string test_name(input logic [3:0] id);
        case (id)
            4'd1:    return "keypad";
            4'd2:    return "presets";
            4'd3:    return "quick_add";
            4'd4:    return "countdown";
            4'd5:    return "stop";
            4'd6:    return "pwm_duty";
            default: return "unknown";
        endcase
    endfunction

    function automatic time_digits_t shift_in(input time_digits_t d, input logic [3:0] k);
        time_digits_t r;
        r.min_tens = d.min_ones;
        r.min_ones = d.sec_tens;
        r.sec_tens = d.sec_ones;
        r.sec_ones = k;
        return r;
    endfunction

    function automatic cook_setting_t keyed_setting(input time_digits_t d);
        cook_setting_t s;
        int            t;
        t = (int'(d.min_tens) * 10 + int'(d.min_ones)) * 60
            + int'(d.sec_tens) * 10 + int'(d.sec_ones);
        if (t > MAX_SECONDS) begin
            t = MAX_SECONDS;
        end
        s.seconds     = seconds_t'(t);
        s.power       = FULL_POWER;
        s.temperature = CUSTOM_TEMPERATURE;
        return s;
    endfunction

    function automatic time_digits_t split_time(input int secs);
        time_digits_t d;
        d.min_tens = 4'(secs / 600);
        d.min_ones = 4'((secs / 60) % 10);
        d.sec_tens = 4'((secs % 60) / 10);
        d.sec_ones = 4'(secs % 10);
        return d;
    endfunction

    // patterns written as gfedcba
    function automatic logic [6:0] seven_seg(input logic [3:0] d);
        case (d)
            4'd0:    return 7'b0111111;
            4'd1:    return 7'b0000110;
            4'd2:    return 7'b1011011;
            4'd3:    return 7'b1001111;
            4'd4:    return 7'b1100110;
            4'd5:    return 7'b1101101;
            4'd6:    return 7'b1111101;
            4'd7:    return 7'b0000111;
            4'd8:    return 7'b1111111;
            4'd9:    return 7'b1101111;
            default: return 7'b0000000;
        endcase
    endfunction

    task automatic model_step();
        logic start_edge;
        logic key_ok;
        int   added;
        // display, buzzer and pwm see the previous cycle's state
        m_mag     = (pwm_phase < int'(m_state.power));
        pwm_phase = (pwm_phase == PWM_PERIOD - 1) ? 0 : pwm_phase + 1;
        m_digits  = split_time(int'(m_state.remaining));
        if (m_fin) begin
            m_beeps = BEEP_TICKS;
        end else if (m_tick && m_beeps > 0) begin
            m_beeps = m_beeps - 1;
        end

        added = int'(m_state.remaining) + QUICK_SECONDS;
        m_fin = 1'b0;
        if (m_cmd.kind == CMD_STOP) begin
            m_state = '0;
        end else if (m_cmd.kind == CMD_START && !m_state.cooking) begin
            m_state.cooking = 1'b1;
            if (m_cmd.setting.seconds == '0) begin
                m_state.remaining   = seconds_t'(QUICK_SECONDS);
                m_state.power       = FULL_POWER;
                m_state.temperature = CUSTOM_TEMPERATURE;
            end else begin
                m_state.remaining   = m_cmd.setting.seconds;
                m_state.power       = m_cmd.setting.power;
                m_state.temperature = m_cmd.setting.temperature;
            end
        end else if (m_cmd.kind == CMD_START) begin
            m_state.remaining = seconds_t'((added > MAX_SECONDS) ? MAX_SECONDS : added);
        end else if (m_tick && m_state.cooking) begin
            m_state.remaining = m_state.remaining - 1'b1;
            if (m_state.remaining == '0) begin
                m_state.cooking = 1'b0;
                m_state.power   = 8'd0;
                m_fin           = 1'b1;
            end
        end
        since_reset = since_reset + 1;
        m_tick      = (since_reset % TICK_CYCLES == 0);

        start_edge    = m_start_now && !m_start_last;
        key_ok        = key_strobe && (key_digit <= 4'd9);
        m_start_last  = m_start_now;
        m_start_now   = start;
        m_cmd.setting = m_pend;
        if (stop) begin
            m_cmd.kind = CMD_STOP;
        end else if (start_edge) begin
            m_cmd.kind = CMD_START;
        end else begin
            m_cmd.kind = CMD_NONE;
        end
        if (stop || start_edge) begin
            m_pend = '0;
        end else if (preset_strobe) begin
            m_pend = PRESET_TABLE[food];
        end else if (key_ok) begin
            m_pend = keyed_setting(shift_in(m_keys, key_digit));
        end
        if (stop || preset_strobe) begin
            m_keys = '0;
        end else if (key_ok) begin
            m_keys = shift_in(m_keys, key_digit);
        end
    endtask

    task automatic check_value(input string what, input logic [31:0] expected,
                               input logic [31:0] actual);
        test_checks = test_checks + 1;
        if (actual !== expected) begin
            test_errors = test_errors + 1;
            error_count = error_count + 1;
            if (test_errors <= 10) begin
                $display("error %s: %s expected %0h actual %0h",
                         test_name(test_id), what, expected, actual);
            end
        end
    endtask

    always @(posedge clk or posedge reset) begin
        if (reset) begin
            m_state      = '0;
            m_cmd        = '0;
            m_pend       = '0;
            m_keys       = '0;
            m_digits     = '0;
            m_start_now  = 1'b0;
            m_start_last = 1'b0;
            m_tick       = 1'b0;
            m_fin        = 1'b0;
            m_mag        = 1'b0;
            m_beeps      = 0;
            pwm_phase    = 0;
            since_reset  = 0;
        end else begin
            model_step();
        end
    end

    // outputs are settled half a cycle after the rising edge
    always @(negedge clk) begin
        if (!reset && since_reset > 0 && !run_done) begin
            check_value("state", m_state, state);
            check_value("digits", m_digits, digits);
            check_value("seg_1", seven_seg(m_digits.sec_ones), seg_1);
            check_value("seg_2", seven_seg(m_digits.sec_tens), seg_2);
            check_value("seg_3", seven_seg(m_digits.min_ones), seg_3);
            check_value("seg_4", seven_seg(m_digits.min_tens), seg_4);
            check_value("magnetron", m_mag, magnetron);
            check_value("buzzer", m_beeps != 0, buzzer);
            check_value("power", m_state.power, power);
            check_value("temperature", m_state.temperature, temperature);
        end
    end

    always @(posedge clk) begin
        if (test_end) begin
            if (test_errors == 0) begin
                tests_passed = tests_passed + 1;
                $display("test %s: passed, %0d checks", test_name(test_id), test_checks);
            end else begin
                tests_failed = tests_failed + 1;
                $display("test %s: failed, %0d of %0d checks wrong",
                         test_name(test_id), test_errors, test_checks);
            end
            test_errors = 0;
            test_checks = 0;
        end
        if (run_end) begin
            $display("tests passed: %0d, tests failed: %0d, errors: %0d",
                     tests_passed, tests_failed, error_count);
            run_done = 1'b1;
        end
    end

endmodule

`default_nettype wire

//--- source/microwave_top.sv
`timescale 1ns/10ps
`default_nettype none

module microwave_top #(
    parameter int unsigned TICK_CYCLES = 50_000_000,
    parameter int unsigned BEEP_TICKS  = 3
) (
    input  wire logic                 clk,
    input  wire logic                 reset,
    input  wire logic [3:0]           key_digit,
    input  wire logic                 key_strobe,
    input  wire microwave_pkg::food_e food,
    input  wire logic                 preset_strobe,
    input  wire logic                 start,
    input  wire logic                 stop,
    output microwave_pkg::cook_state_t  state,
    output microwave_pkg::time_digits_t digits,
    output logic [6:0]                seg_1,
    output logic [6:0]                seg_2,
    output logic [6:0]                seg_3,
    output logic [6:0]                seg_4,
    output logic                      magnetron,
    output logic                      buzzer,
    output logic [7:0]                power,
    output logic [7:0]                temperature
);
    import microwave_pkg::*;

    cook_cmd_t cmd;
    logic      tick;
    logic      finished;

    command_decode u_decode (
        .clk           (clk),
        .reset         (reset),
        .key_digit     (key_digit),
        .key_strobe    (key_strobe),
        .food          (food),
        .preset_strobe (preset_strobe),
        .start         (start),
        .stop          (stop),
        .cmd           (cmd)
    );

    cook_timer #(
        .TICK_CYCLES (TICK_CYCLES)
    ) u_timer (
        .clk      (clk),
        .reset    (reset),
        .cmd      (cmd),
        .state    (state),
        .tick     (tick),
        .finished (finished)
    );

    power_pwm u_pwm (
        .clk       (clk),
        .reset     (reset),
        .power     (state.power),
        .magnetron (magnetron)
    );

    display_alarm #(
        .BEEP_TICKS (BEEP_TICKS)
    ) u_display (
        .clk      (clk),
        .reset    (reset),
        .state    (state),
        .tick     (tick),
        .finished (finished),
        .digits   (digits),
        .seg_1    (seg_1),
        .seg_2    (seg_2),
        .seg_3    (seg_3),
        .seg_4    (seg_4),
        .buzzer   (buzzer)
    );

    assign power       = state.power;
    assign temperature = state.temperature;

endmodule

`default_nettype wire

//--- source/display_alarm.sv
`timescale 1ns/10ps
`default_nettype none

module display_alarm #(
    parameter int unsigned BEEP_TICKS = 3
) (
    input  wire logic                       clk,
    input  wire logic                       reset,
    input  wire microwave_pkg::cook_state_t state,
    input  wire logic                       tick,
    input  wire logic                       finished,
    output microwave_pkg::time_digits_t     digits,
    output logic [6:0]                      seg_1,
    output logic [6:0]                      seg_2,
    output logic [6:0]                      seg_3,
    output logic [6:0]                      seg_4,
    output logic                            buzzer
);
    import microwave_pkg::*;

    localparam int unsigned BEEP_W = (BEEP_TICKS > 0) ? $clog2(BEEP_TICKS + 1) : 1;

    time_digits_t      digits_next;
    logic [BEEP_W-1:0] beep_left;
    int                minutes;
    int                seconds;

    // bit 0 is segment a, bit 6 is segment g
    function automatic logic [6:0] seg_encode(input logic [3:0] digit);
        case (digit)
            4'd0:    return 7'h3f;
            4'd1:    return 7'h06;
            4'd2:    return 7'h5b;
            4'd3:    return 7'h4f;
            4'd4:    return 7'h66;
            4'd5:    return 7'h6d;
            4'd6:    return 7'h7d;
            4'd7:    return 7'h07;
            4'd8:    return 7'h7f;
            4'd9:    return 7'h6f;
            default: return 7'h00;
        endcase
    endfunction

    always_comb begin
        minutes = int'(state.remaining) / 60;
        seconds = int'(state.remaining) % 60;
        digits_next.min_tens = 4'(minutes / 10);
        digits_next.min_ones = 4'(minutes % 10);
        digits_next.sec_tens = 4'(seconds / 10);
        digits_next.sec_ones = 4'(seconds % 10);
    end

    always_ff @(posedge clk) begin
        digits <= digits_next;
        seg_1  <= seg_encode(digits_next.sec_ones);
        seg_2  <= seg_encode(digits_next.sec_tens);
        seg_3  <= seg_encode(digits_next.min_ones);
        seg_4  <= seg_encode(digits_next.min_tens);
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            beep_left <= '0;
        end else if (finished) begin
            beep_left <= BEEP_W'(BEEP_TICKS);
        end else if (tick && (beep_left != '0)) begin
            beep_left <= beep_left - 1'b1;  // falls on the last tick
        end
    end

    assign buzzer = (beep_left != '0);

    // remaining above 99:59 would overflow the minute tens digit
    assert property (@(posedge clk) disable iff (reset)
        (digits.min_tens <= 4'd9) && (digits.min_ones <= 4'd9) &&
        (digits.sec_tens <= 4'd9) && (digits.sec_ones <= 4'd9));

endmodule

`default_nettype wire

//--- source/power_pwm.sv
`timescale 1ns/10ps
`default_nettype none

module power_pwm (
    input  wire logic       clk,
    input  wire logic       reset,
    input  wire logic [7:0] power,
    output logic            magnetron
);
    import microwave_pkg::*;

    localparam int CNT_W = $clog2(PWM_PERIOD);

    logic [CNT_W-1:0] count;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            count     <= '0;
            magnetron <= 1'b0;
        end else begin
            if (count == CNT_W'(PWM_PERIOD - 1)) begin
                count <= '0;
            end else begin
                count <= count + 1'b1;
            end
            magnetron <= (8'(count) < power);  // 0 stays low, 100 stays high
        end
    end

    // duty above 100 percent would mean a broken power setting upstream
    assert property (@(posedge clk) disable iff (reset)
        power <= FULL_POWER);

endmodule

`default_nettype wire

//--- source/cook_timer.sv
`timescale 1ns/10ps
`default_nettype none

module cook_timer #(
    parameter int unsigned TICK_CYCLES = 50_000_000
) (
    input  wire logic                     clk,
    input  wire logic                     reset,
    input  wire microwave_pkg::cook_cmd_t cmd,
    output microwave_pkg::cook_state_t    state,
    output logic                          tick,
    output logic                          finished
);
    import microwave_pkg::*;

    localparam int unsigned DIV_W = (TICK_CYCLES > 1) ? $clog2(TICK_CYCLES) : 1;

    logic [DIV_W-1:0] div_count;
    int               added;
    seconds_t         extended;

    always_comb begin
        added    = int'(state.remaining) + QUICK_SECONDS;
        extended = (added > MAX_SECONDS) ? seconds_t'(MAX_SECONDS) : seconds_t'(added);
    end

    // free running, never restarted by commands
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            div_count <= '0;
            tick      <= 1'b0;
        end else if (div_count == DIV_W'(TICK_CYCLES - 1)) begin
            div_count <= '0;
            tick      <= 1'b1;
        end else begin
            div_count <= div_count + 1'b1;
            tick      <= 1'b0;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state    <= '0;
            finished <= 1'b0;
        end else begin
            finished <= 1'b0;
            case (cmd.kind)
                CMD_STOP: begin
                    state <= '0;  // no finished pulse, so no buzzer
                end
                CMD_START: begin
                    if (!state.cooking) begin
                        state.cooking <= 1'b1;
                        if (cmd.setting.seconds == '0) begin  // quick start
                            state.remaining   <= seconds_t'(QUICK_SECONDS);
                            state.power       <= FULL_POWER;
                            state.temperature <= CUSTOM_TEMPERATURE;
                        end else begin
                            state.remaining   <= cmd.setting.seconds;
                            state.power       <= cmd.setting.power;
                            state.temperature <= cmd.setting.temperature;
                        end
                    end else begin
                        state.remaining <= extended;  // add-30, power kept
                    end
                end
                default: begin
                    if (tick && state.cooking) begin
                        state.remaining <= state.remaining - 1'b1;
                        if (state.remaining == seconds_t'(1)) begin
                            state.cooking <= 1'b0;
                            state.power   <= 8'd0;
                            finished      <= 1'b1;
                        end
                    end
                end
            endcase
        end
    end

    assert property (@(posedge clk) disable iff (reset)
        int'(state.remaining) <= MAX_SECONDS);

    // magnetron must be off whenever the oven is idle
    assert property (@(posedge clk) disable iff (reset)
        !state.cooking |-> state.power == 8'd0);

endmodule

`default_nettype wire

//--- source/command_decode.sv
`timescale 1ns/10ps
`default_nettype none

module command_decode (
    input  wire logic                 clk,
    input  wire logic                 reset,
    input  wire logic [3:0]           key_digit,
    input  wire logic                 key_strobe,
    input  wire microwave_pkg::food_e food,
    input  wire logic                 preset_strobe,
    input  wire logic                 start,
    input  wire logic                 stop,
    output microwave_pkg::cook_cmd_t  cmd
);
    import microwave_pkg::*;

    time_digits_t  buffer;
    time_digits_t  buffer_shifted;
    cook_setting_t pending;
    cook_setting_t keyed_setting;
    logic          key_valid;
    logic          preset_valid;
    logic          start_sample;
    logic          start_prev;
    logic          start_edge;
    int            minutes;
    int            seconds;
    int            total;

    always_comb begin
        key_valid    = key_strobe && (key_digit <= 4'd9);  // non-decimal keys dropped
        preset_valid = preset_strobe && (food <= keep_warm);
        start_edge   = start_sample && !start_prev;

        // oldest digit falls out of min_tens
        buffer_shifted.min_tens = buffer.min_ones;
        buffer_shifted.min_ones = buffer.sec_tens;
        buffer_shifted.sec_tens = buffer.sec_ones;
        buffer_shifted.sec_ones = key_digit;

        minutes = int'(buffer_shifted.min_tens) * 10 + int'(buffer_shifted.min_ones);
        seconds = int'(buffer_shifted.sec_tens) * 10 + int'(buffer_shifted.sec_ones);
        total   = minutes * 60 + seconds;  // seconds field may read up to 99
        if (total > MAX_SECONDS) begin
            total = MAX_SECONDS;
        end

        keyed_setting.seconds     = seconds_t'(total);
        keyed_setting.power       = FULL_POWER;
        keyed_setting.temperature = CUSTOM_TEMPERATURE;
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            buffer       <= '0;
            pending      <= '0;
            start_sample <= 1'b0;
            start_prev   <= 1'b0;
            cmd          <= '{kind: CMD_NONE, setting: '0};
        end else begin
            start_sample <= start;
            start_prev   <= start_sample;

            if (stop || preset_valid) begin
                buffer <= '0;
            end else if (key_valid) begin
                buffer <= buffer_shifted;
            end

            if (stop || start_edge) begin
                pending <= '0;  // setting is consumed by the start
            end else if (preset_valid) begin
                pending <= PRESET_TABLE[food];
            end else if (key_valid) begin
                pending <= keyed_setting;
            end

            if (stop) begin
                cmd.kind <= CMD_STOP;
            end else if (start_edge) begin
                cmd.kind <= CMD_START;
            end else begin
                cmd.kind <= CMD_NONE;
            end
            cmd.setting <= pending;
        end
    end

    // a held start button must not retrigger
    assert property (@(posedge clk) disable iff (reset)
        cmd.kind == CMD_START |=> cmd.kind != CMD_START);

endmodule

`default_nettype wire

//--- source/microwave_pkg.sv
`default_nettype none

package microwave_pkg;

    localparam int MAX_SECONDS = 5999;  // 99:59
    localparam int QUICK_SECONDS = 30;
    localparam logic [7:0] FULL_POWER = 8'd100;
    localparam logic [7:0] CUSTOM_TEMPERATURE = 8'd75;
    localparam int PWM_PERIOD = 100;  // one step per power percent

    typedef logic [12:0] seconds_t;

    typedef enum logic [3:0] {
        popcorn,
        beverage,
        reheat,
        defrost,
        pizza,
        potato,
        vegetable,
        dinner,
        baby_milk,
        keep_warm
    } food_e;

    typedef struct packed {
        seconds_t   seconds;
        logic [7:0] power;
        logic [7:0] temperature;
    } cook_setting_t;

    typedef enum logic [1:0] {
        CMD_NONE,
        CMD_START,
        CMD_STOP
    } cmd_e;

    typedef struct packed {
        cmd_e          kind;
        cook_setting_t setting;
    } cook_cmd_t;

    typedef struct packed {
        logic       cooking;
        seconds_t   remaining;
        logic [7:0] power;
        logic [7:0] temperature;
    } cook_state_t;

    typedef struct packed {
        logic [3:0] min_tens;
        logic [3:0] min_ones;
        logic [3:0] sec_tens;
        logic [3:0] sec_ones;
    } time_digits_t;

    // indexed by food_e
    localparam cook_setting_t PRESET_TABLE [10] = '{
        '{seconds: 13'd120, power: 8'd100, temperature: 8'd100},
        '{seconds: 13'd60,  power: 8'd70,  temperature: 8'd80},
        '{seconds: 13'd90,  power: 8'd70,  temperature: 8'd70},
        '{seconds: 13'd180, power: 8'd35,  temperature: 8'd25},
        '{seconds: 13'd270, power: 8'd80,  temperature: 8'd75},
        '{seconds: 13'd240, power: 8'd100, temperature: 8'd90},
        '{seconds: 13'd210, power: 8'd80,  temperature: 8'd85},
        '{seconds: 13'd180, power: 8'd80,  temperature: 8'd80},
        '{seconds: 13'd60,  power: 8'd50,  temperature: 8'd35},
        '{seconds: 13'd180, power: 8'd10,  temperature: 8'd65}
    };

endpackage

`default_nettype wire
